//--- hw/csi2_stat_pkg.sv
package csi2_stat_pkg;

  // Video stream.
  localparam int PX_W = 16;

  // Width of every error counter and geometry statistic.
  localparam int CNT_W = 32;

  // Error counter slots.
  localparam int NUM_ERR      = 3;
  localparam int ERR_HDR      = 0;
  localparam int ERR_CORR_HDR = 1;
  localparam int ERR_CRC      = 2;

  // Geometry slots for pixels per line and lines per frame.
  localparam int NUM_GEO = 2;
  localparam int GEO_PX  = 0;
  localparam int GEO_LN  = 1;

  // Camera power-up delay in px_clk cycles after reset release.
  localparam int PWUP_DELAY  = 1000;
  localparam int PWUP_CNT_W  = $clog2(PWUP_DELAY);

endpackage

//--- hw/csi2_csr_pkg.sv
package csi2_csr_pkg;

  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Register byte addresses.
  localparam logic [AXIL_ADDR_W-1:0] REG_CTRL         = 8'h00;
  localparam logic [AXIL_ADDR_W-1:0] REG_HDR_ERR      = 8'h04;
  localparam logic [AXIL_ADDR_W-1:0] REG_CORR_HDR_ERR = 8'h08;
  localparam logic [AXIL_ADDR_W-1:0] REG_CRC_ERR      = 8'h0C;
  localparam logic [AXIL_ADDR_W-1:0] REG_MAX_LN       = 8'h10;
  localparam logic [AXIL_ADDR_W-1:0] REG_MIN_LN       = 8'h14;
  localparam logic [AXIL_ADDR_W-1:0] REG_CUR_LN       = 8'h18;
  localparam logic [AXIL_ADDR_W-1:0] REG_MAX_PX       = 8'h1C;
  localparam logic [AXIL_ADDR_W-1:0] REG_MIN_PX       = 8'h20;
  localparam logic [AXIL_ADDR_W-1:0] REG_CUR_PX       = 8'h24;

  // CTRL bit positions.
  localparam int CTRL_PHY_EN     = 0;
  localparam int CTRL_RESET_STAT = 1; // Write-one pulse that reads back as 0.

endpackage

//--- hw/video_if.sv
interface video_if;
  import csi2_stat_pkg::*;

  logic [PX_W-1:0] tdata;
  logic            tvalid;
  logic            tready;
  logic            tuser; // First beat of a frame.
  logic            tlast; // Last beat of a line.

  modport source (
    output tdata, tvalid, tuser, tlast,
    input  tready
  );

  modport sink (
    input  tdata, tvalid, tuser, tlast,
    output tready
  );

  modport monitor (
    input tdata, tvalid, tready, tuser, tlast
  );

endinterface

//--- hw/stat_if.sv
interface stat_if;
  import csi2_stat_pkg::*;

  logic [CNT_W-1:0] hdr_err_cnt;
  logic [CNT_W-1:0] corr_hdr_err_cnt;
  logic [CNT_W-1:0] crc_err_cnt;
  logic [CNT_W-1:0] max_ln;
  logic [CNT_W-1:0] min_ln;
  logic [CNT_W-1:0] cur_ln;
  logic [CNT_W-1:0] max_px;
  logic [CNT_W-1:0] min_px;
  logic [CNT_W-1:0] cur_px;
  logic             reset_stat; // One-cycle clear strobe from the register file.

  modport acc (
    output hdr_err_cnt, corr_hdr_err_cnt, crc_err_cnt,
    output max_ln, min_ln, cur_ln, max_px, min_px, cur_px,
    input  reset_stat
  );

  modport regs (
    input  hdr_err_cnt, corr_hdr_err_cnt, crc_err_cnt,
    input  max_ln, min_ln, cur_ln, max_px, min_px, cur_px,
    output reset_stat
  );

endinterface

//--- hw/axil_if.sv
interface axil_if;
  import csi2_csr_pkg::*;

  logic [AXIL_ADDR_W-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [AXIL_DATA_W-1:0] wdata;
  logic [AXIL_STRB_W-1:0] wstrb;
  logic                   wvalid;
  logic                   wready;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;
  logic [AXIL_ADDR_W-1:0] araddr;
  logic                   arvalid;
  logic                   arready;
  logic [AXIL_DATA_W-1:0] rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

//--- hw/csi2_stat_acc.sv
module csi2_stat_acc (
  input  logic     px_clk_i,
  input  logic     arst_n_i,
  video_if.monitor video_i,
  input  logic     header_err_i,
  input  logic     corr_header_err_i,
  input  logic     crc_err_i,
  stat_if.acc      stat_o
);

  import csi2_stat_pkg::*;

  logic                            beat;
  logic                            sof;
  logic                            eol;
  logic [CNT_W-1:0]                px_cnt;
  logic [CNT_W-1:0]                px_len;
  logic [CNT_W-1:0]                ln_cnt;
  logic                            frame_armed;
  logic [NUM_ERR-1:0]              err_pulse;
  logic [NUM_ERR-1:0][CNT_W-1:0]   err_cnt;
  logic [NUM_GEO-1:0]              geo_close;
  logic [NUM_GEO-1:0][CNT_W-1:0]   geo_val;
  logic [NUM_GEO-1:0][CNT_W-1:0]   geo_cur;
  logic [NUM_GEO-1:0][CNT_W-1:0]   geo_min;
  logic [NUM_GEO-1:0][CNT_W-1:0]   geo_max;

  assign beat   = video_i.tvalid && video_i.tready;
  assign sof    = beat && video_i.tuser;
  assign eol    = beat && video_i.tlast;
  assign px_len = px_cnt + 1'b1; // Includes the current beat.

  assign err_pulse[ERR_HDR]      = header_err_i;
  assign err_pulse[ERR_CORR_HDR] = corr_header_err_i;
  assign err_pulse[ERR_CRC]      = crc_err_i;

  // A line closes on tlast; a frame closes on the next tuser once armed.
  assign geo_close[GEO_PX] = eol;
  assign geo_close[GEO_LN] = sof && frame_armed;
  assign geo_val[GEO_PX]   = px_len;
  assign geo_val[GEO_LN]   = ln_cnt;

  always_ff @(posedge px_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_cnt <= '0;
    end else if (stat_o.reset_stat) begin
      err_cnt <= '0;
    end else begin
      for (int i = 0; i < NUM_ERR; i++) begin
        if (err_pulse[i])
          err_cnt[i] <= err_cnt[i] + 1'b1; // Wraps.
      end
    end
  end

  always_ff @(posedge px_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      px_cnt      <= '0;
      ln_cnt      <= '0;
      frame_armed <= 1'b0;
    end else if (stat_o.reset_stat) begin
      px_cnt      <= '0;
      ln_cnt      <= '0;
      frame_armed <= 1'b0;
    end else begin
      if (eol)
        px_cnt <= '0;
      else if (beat)
        px_cnt <= px_len;
      if (sof) begin
        frame_armed <= 1'b1;
        ln_cnt      <= eol ? CNT_W'(1) : '0; // The tuser beat may also end a line.
      end else if (eol && frame_armed) begin
        ln_cnt <= ln_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge px_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      geo_cur <= '0;
      geo_max <= '0;
      geo_min <= '1;
    end else if (stat_o.reset_stat) begin
      geo_cur <= '0;
      geo_max <= '0;
      geo_min <= '1;
    end else begin
      for (int i = 0; i < NUM_GEO; i++) begin
        if (geo_close[i]) begin
          geo_cur[i] <= geo_val[i];
          if (geo_val[i] < geo_min[i])
            geo_min[i] <= geo_val[i];
          if (geo_val[i] > geo_max[i])
            geo_max[i] <= geo_val[i];
        end
      end
    end
  end

  assign stat_o.hdr_err_cnt      = err_cnt[ERR_HDR];
  assign stat_o.corr_hdr_err_cnt = err_cnt[ERR_CORR_HDR];
  assign stat_o.crc_err_cnt      = err_cnt[ERR_CRC];
  assign stat_o.cur_px           = geo_cur[GEO_PX];
  assign stat_o.min_px           = geo_min[GEO_PX];
  assign stat_o.max_px           = geo_max[GEO_PX];
  assign stat_o.cur_ln           = geo_cur[GEO_LN];
  assign stat_o.min_ln           = geo_min[GEO_LN];
  assign stat_o.max_ln           = geo_max[GEO_LN];

endmodule

//--- hw/csi2_csr.sv
module csi2_csr (
  input  logic  px_clk_i,
  input  logic  arst_n_i,
  axil_if.slave csr_if,
  stat_if.regs  stat_i,
  output logic  phy_en_o
);

  import csi2_csr_pkg::*;

  logic                   wr_hs;
  logic                   rd_hs;
  logic                   wr_ctrl;
  logic                   ctrl_wr;
  logic [AXIL_DATA_W-1:0] rd_data;
  logic [1:0]             rd_resp;

  // One transaction in flight per direction.
  assign wr_hs = csr_if.awvalid && csr_if.wvalid && !csr_if.bvalid;
  assign rd_hs = csr_if.arvalid && !csr_if.rvalid;

  assign csr_if.awready = wr_hs;
  assign csr_if.wready  = wr_hs;
  assign csr_if.arready = rd_hs;

  assign wr_ctrl = csr_if.awaddr == REG_CTRL;
  assign ctrl_wr = wr_hs && wr_ctrl && csr_if.wstrb[0]; // Both CTRL bits live in byte 0.

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (csr_if.araddr)
      REG_CTRL:         rd_data = {{(AXIL_DATA_W-1){1'b0}}, phy_en_o};
      REG_HDR_ERR:      rd_data = stat_i.hdr_err_cnt;
      REG_CORR_HDR_ERR: rd_data = stat_i.corr_hdr_err_cnt;
      REG_CRC_ERR:      rd_data = stat_i.crc_err_cnt;
      REG_MAX_LN:       rd_data = stat_i.max_ln;
      REG_MIN_LN:       rd_data = stat_i.min_ln;
      REG_CUR_LN:       rd_data = stat_i.cur_ln;
      REG_MAX_PX:       rd_data = stat_i.max_px;
      REG_MIN_PX:       rd_data = stat_i.min_px;
      REG_CUR_PX:       rd_data = stat_i.cur_px;
      default:          rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge px_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      csr_if.bvalid     <= 1'b0;
      csr_if.rvalid     <= 1'b0;
      phy_en_o          <= 1'b0;
      stat_i.reset_stat <= 1'b0;
    end else begin
      stat_i.reset_stat <= ctrl_wr && csr_if.wdata[CTRL_RESET_STAT];
      if (ctrl_wr)
        phy_en_o <= csr_if.wdata[CTRL_PHY_EN];
      if (wr_hs)
        csr_if.bvalid <= 1'b1;
      else if (csr_if.bready)
        csr_if.bvalid <= 1'b0;
      if (rd_hs)
        csr_if.rvalid <= 1'b1;
      else if (csr_if.rready)
        csr_if.rvalid <= 1'b0;
    end
  end

  // Response payload is captured with the handshake and held until accepted.
  always_ff @(posedge px_clk_i) begin
    if (wr_hs)
      csr_if.bresp <= wr_ctrl ? RESP_OKAY : RESP_SLVERR;
    if (rd_hs) begin
      csr_if.rdata <= rd_data;
      csr_if.rresp <= rd_resp;
    end
  end

endmodule

//--- hw/cam_pwup.sv
module cam_pwup (
  input  logic px_clk_i,
  input  logic arst_n_i,
  output logic cam_pwup_o
);

  import csi2_stat_pkg::*;

  logic [PWUP_CNT_W-1:0] dly_cnt;
  logic                  dly_done;

  // The counter holds at its last value once the enable is raised.
  assign dly_done = dly_cnt == PWUP_CNT_W'(PWUP_DELAY - 1);

  always_ff @(posedge px_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dly_cnt    <= '0;
      cam_pwup_o <= 1'b0;
    end else if (!cam_pwup_o) begin
      if (dly_done)
        cam_pwup_o <= 1'b1; // Set on the PWUP_DELAY-th edge after release.
      else
        dly_cnt <= dly_cnt + 1'b1;
    end
  end

endmodule

//--- hw/csi2_video_mon.sv
module csi2_video_mon (
  input  logic                                px_clk_i,
  input  logic                                arst_n_i,

  input  logic [csi2_stat_pkg::PX_W-1:0]      video_tdata_i,
  input  logic                                video_tvalid_i,
  input  logic                                video_tuser_i,
  input  logic                                video_tlast_i,
  output logic                                video_tready_o,

  output logic [csi2_stat_pkg::PX_W-1:0]      video_tdata_o,
  output logic                                video_tvalid_o,
  output logic                                video_tuser_o,
  output logic                                video_tlast_o,
  input  logic                                video_tready_i,

  input  logic                                header_err_i,
  input  logic                                corr_header_err_i,
  input  logic                                crc_err_i,

  input  logic                                csr_awvalid_i,
  output logic                                csr_awready_o,
  input  logic [csi2_csr_pkg::AXIL_ADDR_W-1:0] csr_awaddr_i,
  input  logic                                csr_wvalid_i,
  output logic                                csr_wready_o,
  input  logic [csi2_csr_pkg::AXIL_DATA_W-1:0] csr_wdata_i,
  input  logic [csi2_csr_pkg::AXIL_STRB_W-1:0] csr_wstrb_i,
  output logic                                csr_bvalid_o,
  input  logic                                csr_bready_i,
  output logic [1:0]                          csr_bresp_o,
  input  logic                                csr_arvalid_i,
  output logic                                csr_arready_o,
  input  logic [csi2_csr_pkg::AXIL_ADDR_W-1:0] csr_araddr_i,
  output logic                                csr_rvalid_o,
  input  logic                                csr_rready_i,
  output logic [csi2_csr_pkg::AXIL_DATA_W-1:0] csr_rdata_o,
  output logic [1:0]                          csr_rresp_o,

  output logic                                phy_en_o,
  output logic                                cam_pwup_o
);

  video_if video ();
  axil_if  csr_axil ();
  stat_if  stat ();

  // The stream passes straight through; the monitor only taps it.
  assign video.tdata    = video_tdata_i;
  assign video.tvalid   = video_tvalid_i;
  assign video.tuser    = video_tuser_i;
  assign video.tlast    = video_tlast_i;
  assign video.tready   = video_tready_i;
  assign video_tready_o = video.tready;
  assign video_tdata_o  = video.tdata;
  assign video_tvalid_o = video.tvalid;
  assign video_tuser_o  = video.tuser;
  assign video_tlast_o  = video.tlast;

  assign csr_axil.awvalid = csr_awvalid_i;
  assign csr_axil.awaddr  = csr_awaddr_i;
  assign csr_axil.wvalid  = csr_wvalid_i;
  assign csr_axil.wdata   = csr_wdata_i;
  assign csr_axil.wstrb   = csr_wstrb_i;
  assign csr_axil.bready  = csr_bready_i;
  assign csr_axil.arvalid = csr_arvalid_i;
  assign csr_axil.araddr  = csr_araddr_i;
  assign csr_axil.rready  = csr_rready_i;
  assign csr_awready_o    = csr_axil.awready;
  assign csr_wready_o     = csr_axil.wready;
  assign csr_bvalid_o     = csr_axil.bvalid;
  assign csr_bresp_o      = csr_axil.bresp;
  assign csr_arready_o    = csr_axil.arready;
  assign csr_rvalid_o     = csr_axil.rvalid;
  assign csr_rdata_o      = csr_axil.rdata;
  assign csr_rresp_o      = csr_axil.rresp;

  csi2_stat_acc csi2_stat_acc (
    .px_clk_i          ( px_clk_i          ),
    .arst_n_i          ( arst_n_i          ),
    .video_i           ( video             ),
    .header_err_i      ( header_err_i      ),
    .corr_header_err_i ( corr_header_err_i ),
    .crc_err_i         ( crc_err_i         ),
    .stat_o            ( stat              )
  );

  csi2_csr csi2_csr (
    .px_clk_i ( px_clk_i ),
    .arst_n_i ( arst_n_i ),
    .csr_if   ( csr_axil ),
    .stat_i   ( stat     ),
    .phy_en_o ( phy_en_o )
  );

  cam_pwup cam_pwup (
    .px_clk_i   ( px_clk_i   ),
    .arst_n_i   ( arst_n_i   ),
    .cam_pwup_o ( cam_pwup_o )
  );

endmodule

//--- verif/csi2_video_mon_model.svh
`ifndef CSI2_VIDEO_MON_MODEL_SVH
`define CSI2_VIDEO_MON_MODEL_SVH

logic [CNT_W-1:0] m_err [3];
logic [CNT_W-1:0] m_px_cnt;
logic [CNT_W-1:0] m_ln_cnt;
logic [CNT_W-1:0] m_cur_px, m_min_px, m_max_px;
logic [CNT_W-1:0] m_cur_ln, m_min_ln, m_max_ln;
logic             m_armed;
logic             m_phy_en;

function automatic void model_clear();
  for (int i = 0; i < 3; i++)
    m_err[i] = '0;
  m_px_cnt = '0;
  m_ln_cnt = '0;
  m_armed  = 1'b0;
  m_cur_px = '0;
  m_max_px = '0;
  m_min_px = '1;
  m_cur_ln = '0;
  m_max_ln = '0;
  m_min_ln = '1;
endfunction

function automatic void model_errors(input logic hdr, input logic corr, input logic crc);
  m_err[0] += CNT_W'(hdr);
  m_err[1] += CNT_W'(corr);
  m_err[2] += CNT_W'(crc);
endfunction

// One accepted beat; a tuser beat closes the previous frame before it starts a new one.
function automatic void model_beat(input logic user, input logic last);
  logic [CNT_W-1:0] len;
  len = m_px_cnt + 1;
  if (user && m_armed) begin
    m_cur_ln = m_ln_cnt;
    if (m_ln_cnt < m_min_ln) m_min_ln = m_ln_cnt;
    if (m_ln_cnt > m_max_ln) m_max_ln = m_ln_cnt;
  end
  if (last) begin
    m_cur_px = len;
    if (len < m_min_px) m_min_px = len;
    if (len > m_max_px) m_max_px = len;
    m_px_cnt = '0;
  end else begin
    m_px_cnt = len;
  end
  if (user) begin
    m_armed  = 1'b1;
    m_ln_cnt = last ? 1 : 0;
  end else if (last && m_armed) begin
    m_ln_cnt = m_ln_cnt + 1;
  end
endfunction

function automatic void model_read(input logic [7:0] addr, output logic [31:0] data,
                                   output logic [1:0] resp);
  resp = RESP_OKAY;
  case (addr)
    8'h00:   data = {31'b0, m_phy_en};
    8'h04:   data = m_err[0];
    8'h08:   data = m_err[1];
    8'h0C:   data = m_err[2];
    8'h10:   data = m_max_ln;
    8'h14:   data = m_min_ln;
    8'h18:   data = m_cur_ln;
    8'h1C:   data = m_max_px;
    8'h20:   data = m_min_px;
    8'h24:   data = m_cur_px;
    default: begin
      data = '0;
      resp = RESP_SLVERR;
    end
  endcase
endfunction

`endif

//--- verif/tb_csi2_video_mon.sv
module tb_csi2_video_mon;
  timeunit 1ns;
  timeprecision 1ps;

  import csi2_stat_pkg::*;
  import csi2_csr_pkg::*;

  localparam int MAX_FRAMES = 4;
  localparam int MAX_LINES  = 6;
  localparam int MAX_PX     = 12;
  localparam int MAX_GAP    = 3;
  // Cycle budget covers two frame batches, the error burst, register traffic and power-up.
  localparam int VIDEO_CYC = 2 * MAX_FRAMES * MAX_LINES * MAX_PX * (2 * MAX_GAP + 1);
  localparam int RUN_CYC   = 10 + 200 + 64 * 8 + VIDEO_CYC + PWUP_DELAY + 20;

  logic clk, arst_n;
  logic [PX_W-1:0] tdata_i, tdata_o;
  logic tvalid_i, tuser_i, tlast_i, tready_i;
  logic tvalid_o, tuser_o, tlast_o, tready_o;
  logic hdr_err, corr_err, crc_err;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, phy_en, cam_pwup;
  logic [7:0] awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp, resp;
  int errors, test_errs, tests_run, tests_failed, pwup_edges, pwup_errs;

  `include "csi2_video_mon_model.svh"

  csi2_video_mon csi2_video_mon_i (
    .px_clk_i (clk), .arst_n_i (arst_n),
    .video_tdata_i (tdata_i), .video_tvalid_i (tvalid_i), .video_tuser_i (tuser_i),
    .video_tlast_i (tlast_i), .video_tready_o (tready_o),
    .video_tdata_o (tdata_o), .video_tvalid_o (tvalid_o), .video_tuser_o (tuser_o),
    .video_tlast_o (tlast_o), .video_tready_i (tready_i),
    .header_err_i (hdr_err), .corr_header_err_i (corr_err), .crc_err_i (crc_err),
    .csr_awvalid_i (awvalid), .csr_awready_o (awready), .csr_awaddr_i (awaddr),
    .csr_wvalid_i (wvalid), .csr_wready_o (wready), .csr_wdata_i (wdata),
    .csr_wstrb_i (wstrb), .csr_bvalid_o (bvalid), .csr_bready_i (bready),
    .csr_bresp_o (bresp), .csr_arvalid_i (arvalid), .csr_arready_o (arready),
    .csr_araddr_i (araddr), .csr_rvalid_o (rvalid), .csr_rready_i (rready),
    .csr_rdata_o (rdata), .csr_rresp_o (rresp),
    .phy_en_o (phy_en), .cam_pwup_o (cam_pwup)
  );

  always #10 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  task automatic axil_write(input logic [7:0] a, input logic [31:0] d, input logic [3:0] s);
    @(posedge clk);
    #2;
    awaddr = a;
    wdata = d;
    wstrb = s;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_eq("csr_wready_o", 1, 32'(wready));
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid = 1'b0;
    @(negedge clk);
    check_eq("csr_bvalid_o", 1, 32'(bvalid)); // Response follows the handshake by one cycle.
    resp = bresp;
    @(posedge clk);
    #2;
    bready = 1'b0;
    if (a == 8'h00 && s[0]) begin
      m_phy_en = d[0];
      if (d[1]) model_clear();
    end
  endtask

  task automatic check_reg(input logic [7:0] a);
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    @(posedge clk);
    #2;
    araddr = a;
    arvalid = 1'b1;
    rready = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    @(negedge clk);
    check_eq($sformatf("csr_rvalid_o[0x%02h]", a), 1, 32'(rvalid));
    model_read(a, exp_data, exp_resp);
    check_eq($sformatf("rdata[0x%02h]", a), exp_data, rdata);
    check_eq($sformatf("rresp[0x%02h]", a), 32'(exp_resp), 32'(rresp));
    @(posedge clk);
    #2;
    rready = 1'b0;
  endtask

  task automatic check_regs(input logic [7:0] first, input logic [7:0] last);
    for (int a = first; a <= last; a += 4)
      check_reg(8'(a));
  endtask

  task automatic video_cycle(input logic v, input logic r, input logic u, input logic l,
                             input logic [PX_W-1:0] d);
    @(posedge clk);
    #2;
    tvalid_i = v;
    tready_i = r;
    tuser_i = u;
    tlast_i = l;
    tdata_i = d;
    if (v && r) model_beat(u, l);
    #1;
    check_eq("video_tdata_o", 32'(tdata_i), 32'(tdata_o));
    check_eq("video_tvalid_o", 32'(tvalid_i), 32'(tvalid_o));
    check_eq("video_tuser_o", 32'(tuser_i), 32'(tuser_o));
    check_eq("video_tlast_o", 32'(tlast_i), 32'(tlast_o));
    check_eq("video_tready_o", 32'(tready_i), 32'(tready_o));
  endtask

  task automatic send_frames(input int n);
    int lines, px;
    logic [PX_W-1:0] d;
    for (int f = 0; f < n; f++) begin
      lines = 1 + $urandom % MAX_LINES;
      for (int ln = 0; ln < lines; ln++) begin
        px = 1 + $urandom % MAX_PX;
        for (int p = 0; p < px; p++) begin
          d = PX_W'($urandom);
          repeat ($urandom % (MAX_GAP + 1)) video_cycle(0, $urandom % 2, 0, 0, d);
          repeat ($urandom % (MAX_GAP + 1)) video_cycle(1, 0, ln == 0 && p == 0, p == px - 1, d);
          video_cycle(1, 1, ln == 0 && p == 0, p == px - 1, d);
        end
      end
    end
    video_cycle(0, 0, 0, 0, '0);
  endtask

  task automatic send_errors(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      hdr_err = ($urandom % 4) == 0;
      corr_err = ($urandom % 4) == 0;
      crc_err = ($urandom % 4) == 0;
      model_errors(hdr_err, corr_err, crc_err);
    end
    @(posedge clk);
    #2;
    hdr_err = 1'b0;
    corr_err = 1'b0;
    crc_err = 1'b0;
  endtask

  // Camera enable must rise on exactly the PWUP_DELAY-th edge after reset release.
  initial begin
    @(posedge arst_n);
    forever begin
      @(posedge clk);
      pwup_edges++;
      @(negedge clk);
      if (cam_pwup !== (pwup_edges >= PWUP_DELAY)) begin
        $display("ERR %0t cam_pwup_o expected %0b actual %0b", $time,
                 pwup_edges >= PWUP_DELAY, cam_pwup);
        pwup_errs++;
        errors++;
      end
    end
  end

  initial begin
    #(RUN_CYC * 40);
    $display("Watchdog expired, the run did not finish in time.");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    void'($urandom(50));
    clk = 0;
    arst_n = 0;
    tdata_i = '0;
    tvalid_i = 0;
    tuser_i = 0;
    tlast_i = 0;
    tready_i = 0;
    hdr_err = 0;
    corr_err = 0;
    crc_err = 0;
    awvalid = 0;
    awaddr = '0;
    wvalid = 0;
    wdata = '0;
    wstrb = '0;
    bready = 0;
    arvalid = 0;
    araddr = '0;
    rready = 0;
    model_clear();
    m_phy_en = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1;

    @(negedge clk);
    check_eq("csr_bvalid_o", 0, 32'(bvalid));
    check_eq("csr_rvalid_o", 0, 32'(rvalid));
    check_eq("phy_en_o", 0, 32'(phy_en));
    check_regs(8'h00, 8'h24);
    end_test("reset values");

    send_errors(200);
    check_regs(8'h04, 8'h0C);
    end_test("error counters");

    send_frames(MAX_FRAMES);
    check_regs(8'h10, 8'h24);
    end_test("frame geometry");

    axil_write(8'h00, 32'h2, 4'h1);
    check_eq("bresp", 32'(RESP_OKAY), 32'(resp));
    check_regs(8'h00, 8'h24);
    send_frames(2);
    check_regs(8'h10, 8'h24);
    end_test("statistics clear");

    axil_write(8'h00, 32'h1, 4'h1);
    check_eq("phy_en_o", 1, 32'(phy_en));
    axil_write(8'h00, 32'h0, 4'he);
    check_eq("phy_en_o", 1, 32'(phy_en));
    check_reg(8'h00);
    axil_write(8'h04, 32'h5, 4'hf);
    check_eq("bresp", 32'(RESP_SLVERR), 32'(resp));
    check_reg(8'h28);
    check_reg(8'hfc);
    end_test("control and errors");

    while (pwup_edges < PWUP_DELAY + 5) @(posedge clk);
    test_errs += pwup_errs;
    end_test("camera power-up");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- csi2_video_mon.f
+incdir+verif
hw/csi2_stat_pkg.sv
hw/csi2_csr_pkg.sv
hw/video_if.sv
hw/stat_if.sv
hw/axil_if.sv
hw/csi2_stat_acc.sv
hw/csi2_csr.sv
hw/cam_pwup.sv
hw/csi2_video_mon.sv
verif/tb_csi2_video_mon.sv
